// ==== capi_pkg.sv ====
`default_nettype none

`include "cu_consts.svh"

package capi_pkg;

	typedef logic [31:0] label_t;

	// Low half is the vertex label, high half the neighbour label.
	typedef struct packed {
		label_t high;
		label_t low;
	} data_line_t;

	typedef struct packed {
		logic valid;
		logic [`CU_TAG_W-1:0] tag;
		logic [`CU_ADDR_W-1:0] address;
	} read_command_t;

	typedef struct packed {
		logic valid;
		logic [`CU_TAG_W-1:0] tag;
		logic [`CU_ADDR_W-1:0] address;
		data_line_t data;
	} write_command_t;

	// Tag carries the engine index.
	typedef struct packed {
		logic valid;
		logic [`CU_TAG_W-1:0] tag;
	} response_t;

endpackage

`default_nettype wire

// ==== cu_apb_regs.sv ====
`default_nettype none

`include "cu_consts.svh"

module cu_apb_regs (
	input wire logic clock,
	input wire logic rstn,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [`CU_ADDR_W-1:0] paddr,
	input wire logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output cu_pkg::job_config_t job_config,
	output logic start,
	input wire logic busy,
	input wire logic done,
	input wire logic [`CU_VID_W-1:0] done_count
);

	logic access;
	logic mapped;

	assign access = psel & penable;
	assign pready = 1'b1;
	assign pslverr = access & ~mapped;

	// Read mux and address decode.
	always_comb begin
		prdata = '0;
		mapped = 1'b1;
		case (paddr)
			`CU_REG_CTRL: prdata = '0;
			`CU_REG_COUNT: prdata = {{(32 - `CU_VID_W){1'b0}}, job_config.count};
			`CU_REG_RBASE: prdata = job_config.read_base;
			`CU_REG_WBASE: prdata = job_config.write_base;
			`CU_REG_STATUS: prdata = {30'b0, done, busy};
			`CU_REG_DONE_CNT: prdata = {{(32 - `CU_VID_W){1'b0}}, done_count};
			default: mapped = 1'b0;
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_config <= '0;
			start <= 1'b0;
		end else begin
			start <= 1'b0;
			if (access && pwrite) begin
				case (paddr)
					// Start is dropped while a job runs.
					`CU_REG_CTRL: start <= pwdata[0] & ~busy;
					`CU_REG_COUNT: job_config.count <= pwdata[`CU_VID_W-1:0];
					`CU_REG_RBASE: job_config.read_base <= pwdata;
					`CU_REG_WBASE: job_config.write_base <= pwdata;
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== cu_command_arbiter.sv ====
`default_nettype none

module cu_command_arbiter #(
	parameter int num_req = 2,
	parameter type payload_t = logic
) (
	input wire logic clock,
	input wire logic rstn,
	input wire logic [num_req-1:0] request,
	input payload_t command [num_req],
	output logic [num_req-1:0] grant,
	output payload_t out,
	input wire logic out_ready
);

	localparam int idx_w = (num_req > 1) ? $clog2(num_req) : 1;

	logic [idx_w-1:0] last;
	logic [idx_w-1:0] winner;
	logic found;
	logic full;
	logic load;
	logic accept;

	// Search starts one past the last winner.
	always_comb begin
		int idx;
		winner = last;
		found = 1'b0;
		for (int k = 1; k <= num_req; k++) begin
			idx = (int'(last) + k) % num_req;
			if (!found && request[idx]) begin
				winner = idx_w'(idx);
				found = 1'b1;
			end
		end
	end

	assign accept = full & out_ready;
	assign load = found & (~full | out_ready);

	always_comb begin
		for (int i = 0; i < num_req; i++) begin
			grant[i] = load && (winner == idx_w'(i));
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			full <= 1'b0;
			out <= '0;
			last <= idx_w'(num_req - 1);
		end else if (load) begin
			full <= 1'b1;
			out <= command[winner];
			last <= winner;
		end else if (accept) begin
			full <= 1'b0;
			out <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== cu_consts.svh ====
`ifndef CU_CONSTS_SVH
`define CU_CONSTS_SVH

// Engine count and field widths.
`define CU_NUM_CU 2
`define CU_TAG_W 4
`define CU_ADDR_W 32
`define CU_VID_W 16

// APB register byte offsets.
`define CU_REG_CTRL 32'h00
`define CU_REG_COUNT 32'h04
`define CU_REG_RBASE 32'h08
`define CU_REG_WBASE 32'h0C
`define CU_REG_STATUS 32'h10
`define CU_REG_DONE_CNT 32'h14

`endif

// ==== cu_graph_algorithm_control.sv ====
`default_nettype none

`include "cu_consts.svh"

module cu_graph_algorithm_control #(
	parameter int num_cu = `CU_NUM_CU
) (
	input wire logic clock,
	input wire logic rstn,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [`CU_ADDR_W-1:0] paddr,
	input wire logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output capi_pkg::read_command_t read_command_out,
	input wire logic read_command_ready,
	output capi_pkg::write_command_t write_command_out,
	input wire logic write_command_ready,
	input capi_pkg::response_t read_response_in,
	input capi_pkg::data_line_t read_data_in,
	input capi_pkg::response_t write_response_in
);

	import capi_pkg::*;
	import cu_pkg::*;

	job_config_t job_config;
	logic start;
	logic busy;
	logic done;
	logic [`CU_VID_W-1:0] done_count;

	vertex_job_t [num_cu-1:0] job;
	logic [num_cu-1:0] job_ready;
	logic [num_cu-1:0] complete;
	logic [num_cu-1:0] read_request;
	logic [num_cu-1:0] read_grant;
	logic [num_cu-1:0] write_request;
	logic [num_cu-1:0] write_grant;
	logic [num_cu-1:0] read_valid;
	logic [num_cu-1:0] write_valid;
	read_command_t read_command [num_cu];
	write_command_t write_command [num_cu];

	response_t read_response_q;
	response_t write_response_q;
	data_line_t read_data_q;

	// ====================================================================
	// Response input registers and tag routing
	// ====================================================================

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_response_q <= '0;
			write_response_q <= '0;
		end else begin
			read_response_q <= read_response_in;
			write_response_q <= write_response_in;
		end
	end

	always_ff @(posedge clock) begin
		read_data_q <= read_data_in;
	end

	always_comb begin
		for (int i = 0; i < num_cu; i++) begin
			read_valid[i] = read_response_q.valid && (read_response_q.tag == `CU_TAG_W'(i));
			write_valid[i] = write_response_q.valid && (write_response_q.tag == `CU_TAG_W'(i));
		end
	end

	// ====================================================================
	// Configuration and sequencing
	// ====================================================================

	cu_apb_regs u_regs (
		.clock(clock),
		.rstn(rstn),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.job_config(job_config),
		.start(start),
		.busy(busy),
		.done(done),
		.done_count(done_count)
	);

	cu_job_sequencer #(.num_cu(num_cu)) u_sequencer (
		.clock(clock),
		.rstn(rstn),
		.start(start),
		.job_config(job_config),
		.job(job),
		.job_ready(job_ready),
		.complete(complete),
		.busy(busy),
		.done(done),
		.done_count(done_count)
	);

	// ====================================================================
	// Engines and command arbitration
	// ====================================================================

	for (genvar i = 0; i < num_cu; i++) begin : g_engine
		cu_vertex_engine #(.index(i)) u_engine (
			.clock(clock),
			.rstn(rstn),
			.job(job[i]),
			.job_ready(job_ready[i]),
			.read_base(job_config.read_base),
			.write_base(job_config.write_base),
			.read_request(read_request[i]),
			.read_command(read_command[i]),
			.read_grant(read_grant[i]),
			.read_response(read_valid[i]),
			.read_data(read_data_q),
			.write_request(write_request[i]),
			.write_command(write_command[i]),
			.write_grant(write_grant[i]),
			.write_response(write_valid[i]),
			.complete(complete[i])
		);
	end

	cu_command_arbiter #(.num_req(num_cu), .payload_t(read_command_t)) u_read_arbiter (
		.clock(clock),
		.rstn(rstn),
		.request(read_request),
		.command(read_command),
		.grant(read_grant),
		.out(read_command_out),
		.out_ready(read_command_ready)
	);

	cu_command_arbiter #(.num_req(num_cu), .payload_t(write_command_t)) u_write_arbiter (
		.clock(clock),
		.rstn(rstn),
		.request(write_request),
		.command(write_command),
		.grant(write_grant),
		.out(write_command_out),
		.out_ready(write_command_ready)
	);

endmodule

`default_nettype wire

// ==== cu_job_sequencer.sv ====
`default_nettype none

`include "cu_consts.svh"

module cu_job_sequencer #(
	parameter int num_cu = `CU_NUM_CU
) (
	input wire logic clock,
	input wire logic rstn,
	input wire logic start,
	input cu_pkg::job_config_t job_config,
	output cu_pkg::vertex_job_t [num_cu-1:0] job,
	input wire logic [num_cu-1:0] job_ready,
	input wire logic [num_cu-1:0] complete,
	output logic busy,
	output logic done,
	output logic [`CU_VID_W-1:0] done_count
);

	import cu_pkg::*;

	seq_state_t state;
	logic launch;
	logic dispatch;
	logic all_issued;
	logic all_done;
	logic [`CU_VID_W-1:0] issued_count;
	logic [num_cu-1:0] sel;

	assign launch = start && (state == SEQ_IDLE);
	assign dispatch = (state == SEQ_ISSUE) && !all_issued && (|job_ready);
	assign busy = (state != SEQ_IDLE);

	cu_vertex_counter #(.num_cu(num_cu)) u_counter (
		.clock(clock),
		.rstn(rstn),
		.clear(launch),
		.issue(dispatch),
		.complete(complete),
		.target(job_config.count),
		.issued_count(issued_count),
		.completed_count(done_count),
		.all_issued(all_issued),
		.all_done(all_done)
	);

	// Lowest-indexed free engine takes the next id.
	always_comb begin
		logic found;
		found = 1'b0;
		sel = '0;
		for (int i = 0; i < num_cu; i++) begin
			if (job_ready[i] && !found) begin
				sel[i] = 1'b1;
				found = 1'b1;
			end
		end
		for (int i = 0; i < num_cu; i++) begin
			job[i].valid = dispatch & sel[i];
			job[i].vid = issued_count;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= SEQ_IDLE;
			done <= 1'b0;
		end else begin
			case (state)
				SEQ_IDLE: if (start) begin
					done <= 1'b0;
					state <= (job_config.count == '0) ? SEQ_DONE : SEQ_ISSUE;
				end
				SEQ_ISSUE: if (all_issued) state <= SEQ_DRAIN;
				SEQ_DRAIN: if (all_done) state <= SEQ_DONE;
				SEQ_DONE: begin
					done <= 1'b1;
					state <= SEQ_IDLE;
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== cu_pkg.sv ====
`default_nettype none

`include "cu_consts.svh"

package cu_pkg;

	typedef struct packed {
		logic valid;
		logic [`CU_VID_W-1:0] vid;
	} vertex_job_t;

	typedef struct packed {
		logic [`CU_VID_W-1:0] count;
		logic [`CU_ADDR_W-1:0] read_base;
		logic [`CU_ADDR_W-1:0] write_base;
	} job_config_t;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_ISSUE,
		SEQ_DRAIN,
		SEQ_DONE
	} seq_state_t;

endpackage

`default_nettype wire

// ==== cu_vertex_counter.sv ====
`default_nettype none

`include "cu_consts.svh"

module cu_vertex_counter #(
	parameter int num_cu = `CU_NUM_CU
) (
	input wire logic clock,
	input wire logic rstn,
	input wire logic clear,
	input wire logic issue,
	input wire logic [num_cu-1:0] complete,
	input wire logic [`CU_VID_W-1:0] target,
	output logic [`CU_VID_W-1:0] issued_count,
	output logic [`CU_VID_W-1:0] completed_count,
	output logic all_issued,
	output logic all_done
);

	logic [`CU_VID_W-1:0] finished;

	// Engines finishing this cycle.
	always_comb begin
		finished = '0;
		for (int i = 0; i < num_cu; i++) begin
			finished = finished + `CU_VID_W'(complete[i]);
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			issued_count <= '0;
			completed_count <= '0;
		end else if (clear) begin
			issued_count <= '0;
			completed_count <= '0;
		end else begin
			if (issue) begin
				issued_count <= issued_count + `CU_VID_W'(1);
			end
			completed_count <= completed_count + finished;
		end
	end

	assign all_issued = (issued_count == target);
	assign all_done = (completed_count == target);

endmodule

`default_nettype wire

// ==== cu_vertex_engine.sv ====
`default_nettype none

`include "cu_consts.svh"

module cu_vertex_engine #(
	parameter int index = 0
) (
	input wire logic clock,
	input wire logic rstn,
	input cu_pkg::vertex_job_t job,
	output logic job_ready,
	input wire logic [`CU_ADDR_W-1:0] read_base,
	input wire logic [`CU_ADDR_W-1:0] write_base,
	output logic read_request,
	output capi_pkg::read_command_t read_command,
	input wire logic read_grant,
	input wire logic read_response,
	input capi_pkg::data_line_t read_data,
	output logic write_request,
	output capi_pkg::write_command_t write_command,
	input wire logic write_grant,
	input wire logic write_response,
	output logic complete
);

	import capi_pkg::*;

	typedef enum logic [2:0] {
		ENG_IDLE,
		ENG_READ,
		ENG_READ_WAIT,
		ENG_WRITE,
		ENG_WRITE_WAIT
	} eng_state_t;

	eng_state_t state;
	logic [`CU_VID_W-1:0] vid;
	label_t min_label;
	logic [`CU_ADDR_W-1:0] line_offset;

	// Each vertex owns one 8-byte line.
	assign line_offset = `CU_ADDR_W'(vid) << 3;

	assign job_ready = (state == ENG_IDLE);
	assign read_request = (state == ENG_READ);
	assign write_request = (state == ENG_WRITE);
	assign complete = (state == ENG_WRITE_WAIT) && write_response;

	always_comb begin
		read_command.valid = read_request;
		read_command.tag = `CU_TAG_W'(index);
		read_command.address = read_base + line_offset;
		write_command.valid = write_request;
		write_command.tag = `CU_TAG_W'(index);
		write_command.address = write_base + line_offset;
		write_command.data.high = '0;
		write_command.data.low = min_label;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= ENG_IDLE;
		end else begin
			case (state)
				ENG_IDLE: if (job.valid) state <= ENG_READ;
				ENG_READ: if (read_grant) state <= ENG_READ_WAIT;
				ENG_READ_WAIT: if (read_response) state <= ENG_WRITE;
				ENG_WRITE: if (write_grant) state <= ENG_WRITE_WAIT;
				ENG_WRITE_WAIT: if (write_response) state <= ENG_IDLE;
				default: state <= ENG_IDLE;
			endcase
		end
	end

	// Vertex id and result.
	always_ff @(posedge clock) begin
		if (state == ENG_IDLE && job.valid) begin
			vid <= job.vid;
		end
		if (state == ENG_READ_WAIT && read_response) begin
			min_label <= (read_data.low < read_data.high) ? read_data.low : read_data.high;
		end
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
capi_pkg.sv
cu_pkg.sv
cu_apb_regs.sv
cu_vertex_counter.sv
cu_job_sequencer.sv
cu_vertex_engine.sv
cu_command_arbiter.sv
cu_graph_algorithm_control.sv
tb_cu_graph_algorithm_control.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f \
	--top-module tb_cu_graph_algorithm_control --Mdir obj_dir -o tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

echo "Simulation finished"
exit 0

// ==== tb_cu_graph_algorithm_control.sv ====
`default_nettype none

`include "cu_consts.svh"

module tb_cu_graph_algorithm_control;

	timeunit 1ns;
	timeprecision 1ps;

	import capi_pkg::*;

	typedef struct packed {
		logic [`CU_TAG_W-1:0] tag;
		logic [`CU_VID_W-1:0] vid;
	} pending_t;

	logic clock;
	logic rstn;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	read_command_t read_command_out;
	logic read_command_ready;
	write_command_t write_command_out;
	logic write_command_ready;
	response_t read_response_in;
	data_line_t read_data_in;
	response_t write_response_in;

	logic [15:0] lfsr;
	logic [63:0] mem [int];
	int read_seen [int];
	int write_seen [int];
	logic tag_open [16];
	logic [`CU_VID_W-1:0] tag_vid [16];
	pending_t read_queue [$];
	pending_t write_queue [$];
	logic [31:0] cur_rbase;
	logic [31:0] cur_wbase;
	int cur_count;
	int command_cycles;
	read_command_t held_read;
	write_command_t held_write;
	logic read_held;
	logic write_held;

	cu_graph_algorithm_control uut (
		.clock(clock),
		.rstn(rstn),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.read_command_out(read_command_out),
		.read_command_ready(read_command_ready),
		.write_command_out(write_command_out),
		.write_command_ready(write_command_ready),
		.read_response_in(read_response_in),
		.read_data_in(read_data_in),
		.write_response_in(write_response_in)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit.
	function automatic logic [63:0] random_bits(input int count);
		logic [63:0] bits;
		logic feedback;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], feedback};
			bits = {bits[62:0], feedback};
		end
		return bits;
	endfunction

	function automatic logic [31:0] lower_label(input logic [31:0] a, input logic [31:0] b);
		return (a < b) ? a : b;
	endfunction

	task automatic fail_run();
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		assert (got == expected) else begin
			$display("MISMATCH %s: got %h expected %h", name, got, expected);
			fail_run();
		end
	endtask

	// ======================================================================
	// APB host
	// ======================================================================

	task automatic apb_access(input logic write, input logic [31:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int waited;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(posedge clock);
		#1;
		penable = 1'b1;
		waited = 0;
		forever begin
			@(negedge clock);
			if (pready) break;
			waited++;
			assert (waited < 16) else begin
				$display("APB access to %h never saw pready", addr);
				fail_run();
			end
		end
		rdata = prdata;
		err = pslverr;
		@(posedge clock);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		logic err;
		apb_access(1'b1, addr, data, unused, err);
		assert (!err) else begin
			$display("APB write to %h raised pslverr", addr);
			fail_run();
		end
	endtask

	task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
		logic err;
		apb_access(1'b0, addr, 32'h0, data, err);
		assert (!err) else begin
			$display("APB read from %h raised pslverr", addr);
			fail_run();
		end
	endtask

	task automatic wait_done(input int max_polls);
		logic [31:0] status;
		int polls;
		polls = 0;
		forever begin
			apb_read(`CU_REG_STATUS, status);
			if (status[1]) break;
			polls++;
			assert (polls < max_polls) else begin
				$display("Job did not finish within %0d status polls", max_polls);
				fail_run();
			end
		end
		check_value("STATUS", status, 32'h2);
	endtask

	// ======================================================================
	// Memory model
	// ======================================================================

	task automatic take_read(input read_command_t cmd);
		logic [31:0] offset;
		int vid;
		pending_t entry;
		offset = cmd.address - cur_rbase;
		vid = int'(offset >> 3);
		assert (offset[2:0] == 3'b0 && vid < cur_count) else begin
			$display("Read address %h is outside the job's read range", cmd.address);
			fail_run();
		end
		assert (int'(cmd.tag) < `CU_NUM_CU && !tag_open[cmd.tag]) else begin
			$display("Read carries tag %0d that is invalid or still open", cmd.tag);
			fail_run();
		end
		assert (!read_seen.exists(vid)) else begin
			$display("Vertex %0d was read twice", vid);
			fail_run();
		end
		read_seen[vid] = 1;
		tag_open[cmd.tag] = 1'b1;
		tag_vid[cmd.tag] = `CU_VID_W'(vid);
		entry.tag = cmd.tag;
		entry.vid = `CU_VID_W'(vid);
		read_queue.push_back(entry);
	endtask

	task automatic take_write(input write_command_t cmd);
		logic [31:0] expect_addr;
		logic [63:0] line;
		logic [63:0] expect_data;
		int vid;
		pending_t entry;
		assert (int'(cmd.tag) < `CU_NUM_CU && tag_open[cmd.tag]) else begin
			$display("Write carries tag %0d with no read before it", cmd.tag);
			fail_run();
		end
		vid = int'(tag_vid[cmd.tag]);
		expect_addr = cur_wbase + (32'(vid) << 3);
		check_value("write_command_out.address", cmd.address, expect_addr);
		line = mem[vid];
		expect_data = {32'h0, lower_label(line[31:0], line[63:32])};
		assert (cmd.data == expect_data) else begin
			$display("MISMATCH write_command_out.data: got %h expected %h",
				cmd.data, expect_data);
			fail_run();
		end
		assert (!write_seen.exists(vid)) else begin
			$display("Vertex %0d was written twice", vid);
			fail_run();
		end
		write_seen[vid] = 1;
		tag_open[cmd.tag] = 1'b0;
		entry.tag = cmd.tag;
		entry.vid = `CU_VID_W'(vid);
		write_queue.push_back(entry);
	endtask

	// Outputs are settled at the falling edge.
	always @(negedge clock) begin
		if (rstn) begin
			if (read_command_out.valid || write_command_out.valid) command_cycles++;
			if (read_held) begin
				assert (read_command_out == held_read) else begin
					$display("MISMATCH read_command_out: got %h expected %h",
						read_command_out, held_read);
					fail_run();
				end
			end
			if (write_held) begin
				assert (write_command_out == held_write) else begin
					$display("MISMATCH write_command_out: got %h expected %h",
						write_command_out, held_write);
					fail_run();
				end
			end
			if (read_command_out.valid && read_command_ready) take_read(read_command_out);
			if (write_command_out.valid && write_command_ready) take_write(write_command_out);
			held_read = read_command_out;
			held_write = write_command_out;
			read_held = read_command_out.valid && !read_command_ready;
			write_held = write_command_out.valid && !write_command_ready;
		end
	end

	// Responses in order, each after 0 to 3 idle cycles.
	initial begin
		int read_wait;
		int write_wait;
		logic [63:0] bits;
		pending_t head;
		read_wait = -1;
		write_wait = -1;
		forever begin
			@(posedge clock);
			#1;
			bits = random_bits(2);
			read_command_ready = bits[0];
			write_command_ready = bits[1];
			read_response_in = '0;
			read_data_in = '0;
			write_response_in = '0;
			if (read_queue.size() > 0) begin
				if (read_wait < 0) begin
					bits = random_bits(2);
					read_wait = int'(bits[1:0]);
				end
				if (read_wait == 0) begin
					head = read_queue.pop_front();
					read_response_in.valid = 1'b1;
					read_response_in.tag = head.tag;
					read_data_in = mem[int'(head.vid)];
				end
				read_wait--;
			end
			if (write_queue.size() > 0) begin
				if (write_wait < 0) begin
					bits = random_bits(2);
					write_wait = int'(bits[1:0]);
				end
				if (write_wait == 0) begin
					head = write_queue.pop_front();
					write_response_in.valid = 1'b1;
					write_response_in.tag = head.tag;
				end
				write_wait--;
			end
		end
	end

	// ======================================================================
	// Jobs
	// ======================================================================

	task automatic run_job(input int count, input logic [31:0] rbase,
			input logic [31:0] wbase, input logic restart_while_busy);
		logic [31:0] value;
		int cycles_before;
		apb_write(`CU_REG_COUNT, 32'(count));
		apb_write(`CU_REG_RBASE, rbase);
		apb_write(`CU_REG_WBASE, wbase);
		apb_read(`CU_REG_COUNT, value);
		check_value("COUNT", value, 32'(count));
		apb_read(`CU_REG_RBASE, value);
		check_value("RBASE", value, rbase);
		apb_read(`CU_REG_WBASE, value);
		check_value("WBASE", value, wbase);
		cur_count = count;
		cur_rbase = rbase;
		cur_wbase = wbase;
		read_seen.delete();
		write_seen.delete();
		cycles_before = command_cycles;
		apb_write(`CU_REG_CTRL, 32'h1);
		apb_read(`CU_REG_STATUS, value);
		check_value("STATUS", value, 32'h1);
		if (restart_while_busy) begin
			apb_write(`CU_REG_CTRL, 32'h1);
			apb_read(`CU_REG_STATUS, value);
			check_value("STATUS", value, 32'h1);
		end
		wait_done(1000);
		apb_read(`CU_REG_DONE_CNT, value);
		check_value("DONE_CNT", value, 32'(count));
		check_value("vertices read", 32'(read_seen.size()), 32'(count));
		check_value("vertices written", 32'(write_seen.size()), 32'(count));
		if (count == 0) begin
			check_value("command cycles", 32'(command_cycles), 32'(cycles_before));
		end
	endtask

	initial begin
		logic [31:0] value;
		logic err;
		rstn = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		read_command_ready = 1'b0;
		write_command_ready = 1'b0;
		read_response_in = '0;
		read_data_in = '0;
		write_response_in = '0;
		command_cycles = 0;
		read_held = 1'b0;
		write_held = 1'b0;
		cur_count = 0;
		cur_rbase = '0;
		cur_wbase = '0;
		for (int t = 0; t < 16; t++) begin
			tag_open[t] = 1'b0;
			tag_vid[t] = '0;
		end
		lfsr = 16'd24;
		for (int v = 0; v < 64; v++) begin
			mem[v] = random_bits(64);
		end
		repeat (4) @(posedge clock);
		#1;
		assert (!read_command_out.valid && !write_command_out.valid) else begin
			$display("A command valid is high during reset");
			fail_run();
		end
		rstn = 1'b1;
		apb_read(`CU_REG_STATUS, value);
		check_value("STATUS", value, 32'h0);
		apb_access(1'b0, 32'h18, 32'h0, value, err);
		assert (err) else begin
			$display("Read of unmapped offset 0x18 did not raise pslverr");
			fail_run();
		end
		apb_access(1'b1, 32'h18, 32'h0, value, err);
		assert (err) else begin
			$display("Write to unmapped offset 0x18 did not raise pslverr");
			fail_run();
		end
		run_job(37, 32'h1000_0000, 32'h2000_0000, 1'b1);
		run_job(23, 32'h0004_0100, 32'h3000_0800, 1'b0);
		run_job(0, 32'h0005_0000, 32'h0006_0000, 1'b0);
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire
